//--- src/arcade_input_config.svh
// Constants for the player-input path, scan codes in PS/2 set 2
// Pad type IDs follow the LLAPI controller list
// Button positions index the 32-bit LLAPI button word
`ifndef ARCADE_INPUT_CONFIG_SVH
`define ARCADE_INPUT_CONFIG_SVH

// Keyboard scan codes of the used keys
`define PS2_CODE_UP     8'h75
`define PS2_CODE_DOWN   8'h72
`define PS2_CODE_LEFT   8'h6B
`define PS2_CODE_RIGHT  8'h74
`define PS2_CODE_CTRL   8'h14
`define PS2_CODE_ALT    8'h11
`define PS2_CODE_SPACE  8'h29
`define PS2_CODE_1      8'h16
`define PS2_CODE_2      8'h1E
`define PS2_CODE_5      8'h2E
`define PS2_CODE_6      8'h36
`define PS2_CODE_A      8'h1C
`define PS2_CODE_S      8'h1B
`define PS2_CODE_Q      8'h15
`define PS2_CODE_R      8'h2D
`define PS2_CODE_F      8'h2B
`define PS2_CODE_D      8'h23
`define PS2_CODE_G      8'h34
`define PS2_CODE_P      8'h4D

// Key word bit positions
`define PS2_TOGGLE_BIT  10
`define PS2_PRESSED_BIT 9

// Six-button controller types
`define LLAPI_TYPE_SIX_A      8'd20
`define LLAPI_TYPE_SIX_B      8'd21
`define LLAPI_TYPE_SIX_C      8'd8
`define LLAPI_TYPE_SIX_D      8'd3
`define LLAPI_TYPE_SIX_E      8'd11
`define LLAPI_TYPE_NEC_AVENUE 8'd54

// Button word positions
`define LLAPI_BTN_UP    27
`define LLAPI_BTN_DOWN  26
`define LLAPI_BTN_LEFT  25
`define LLAPI_BTN_RIGHT 24
`define LLAPI_BTN_START 5
`define LLAPI_BTN_COIN  4
`define LLAPI_BTN_0     0
`define LLAPI_BTN_1     1
`define LLAPI_BTN_2     2
`define LLAPI_BTN_7     7

// Download indexes
`define DL_INDEX_GAME 8'd1
`define DL_INDEX_DIP  8'd254

`endif

//--- src/arcade_input_pkg.sv
// Shared types of the player-input path
// Struct field order is the bit order, first field is the MSB
package arcade_input_pkg;

	// Raw bus widths
	typedef logic [10:0] ps2_key_t;
	typedef logic [31:0] llapi_buttons_t;
	typedef logic [7:0]  llapi_type_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  game_index_t;

	// Held pressed state, one bit per used key
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic ctrl;
		logic alt;
		logic space;
		logic k1;
		logic k2;
		logic k5;
		logic k6;
		logic a;
		logic s;
		logic q;
		logic r;
		logic f;
		logic d;
		logic g;
		logic p;
	} kbd_keys_t;

	// One pad after layout mapping
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic b0;
		logic b1;
		logic b2;
		logic start;
		logic coin;
	} pad_t;

	// Player control word as the game core expects it
	typedef struct packed {
		struct packed {
			logic up;
			logic down;
			logic right;
			logic left;
		} joy;
		struct packed {
			logic b2;
			logic b1;
			logic b0;
		} buttons;
		logic start;
		logic coin;
	} player_ctrl_t;

endpackage

//--- src/ps2_key_decoder.sv
// Key word must hold until the next toggle change
// First event after reset must carry toggle 1
// Keys update on the second edge after an event is applied
`timescale 1ns/10ps
`include "arcade_input_config.svh"

module ps2_key_decoder import arcade_input_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  ps2_key_t  ps2_key,
	output kbd_keys_t keys
);

	////////////////////////////////////////////////////////////////////////////
	// Input stage
	////////////////////////////////////////////////////////////////////////////

	// Staged key word and the toggle seen one edge before it
	ps2_key_t ps2_q;
	logic     toggle_q;
	logic     key_event;
	logic     pressed;
	byte_t    code;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ps2_q    <= '0;
			toggle_q <= 1'b0;
		end else begin
			ps2_q    <= ps2_key;
			toggle_q <= ps2_q[`PS2_TOGGLE_BIT];
		end
	end

	// New event whenever the staged toggle moved
	assign key_event = ps2_q[`PS2_TOGGLE_BIT] != toggle_q;
	assign pressed   = ps2_q[`PS2_PRESSED_BIT];
	assign code      = ps2_q[7:0];

	////////////////////////////////////////////////////////////////////////////
	// Held key state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// All released
			keys <= '0;
		end else if (key_event) begin
			case (code)
				`PS2_CODE_UP:    keys.up    <= pressed;
				`PS2_CODE_DOWN:  keys.down  <= pressed;
				`PS2_CODE_LEFT:  keys.left  <= pressed;
				`PS2_CODE_RIGHT: keys.right <= pressed;
				`PS2_CODE_CTRL:  keys.ctrl  <= pressed;
				`PS2_CODE_ALT:   keys.alt   <= pressed;
				`PS2_CODE_SPACE: keys.space <= pressed;
				`PS2_CODE_1:     keys.k1    <= pressed;
				`PS2_CODE_2:     keys.k2    <= pressed;
				`PS2_CODE_5:     keys.k5    <= pressed;
				`PS2_CODE_6:     keys.k6    <= pressed;
				`PS2_CODE_A:     keys.a     <= pressed;
				`PS2_CODE_S:     keys.s     <= pressed;
				`PS2_CODE_Q:     keys.q     <= pressed;
				`PS2_CODE_R:     keys.r     <= pressed;
				`PS2_CODE_F:     keys.f     <= pressed;
				`PS2_CODE_D:     keys.d     <= pressed;
				`PS2_CODE_G:     keys.g     <= pressed;
				`PS2_CODE_P:     keys.p     <= pressed;
				// Unused codes leave the state alone
				default: ;
			endcase
		end
	end

endmodule

//--- src/llapi_pad_mapper.sv
// Buttons and type are decoded LLAPI words, levels on clk_sys
// Type 0 or 255 counts as no pad until a button is seen
// Only the seen flag is registered, the rest is combinational
`timescale 1ns/10ps
`include "arcade_input_config.svh"

module llapi_pad_mapper import arcade_input_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           link_en,
	input  llapi_buttons_t buttons,
	input  llapi_type_t    pad_type,
	output pad_t           pad,
	output logic           osd_combo
);

	logic button_seen;
	logic type_known;
	logic present;
	logic fire_0;
	logic fire_1;
	logic fire_2;

	// Sticky until reset, catches pads that report type 0
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			button_seen <= 1'b0;
		end else if (|buttons) begin
			button_seen <= 1'b1;
		end
	end

	assign type_known = (pad_type != '0) && (pad_type != '1);
	assign present    = link_en && (type_known || button_seen);

	////////////////////////////////////////////////////////////////////////////
	// Fire button layout per controller type
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (pad_type)
			`LLAPI_TYPE_SIX_A, `LLAPI_TYPE_SIX_B, `LLAPI_TYPE_SIX_C,
			`LLAPI_TYPE_SIX_D, `LLAPI_TYPE_SIX_E: begin
				fire_0 = buttons[`LLAPI_BTN_0];
				fire_1 = buttons[`LLAPI_BTN_1];
				fire_2 = buttons[`LLAPI_BTN_7];
			end
			`LLAPI_TYPE_NEC_AVENUE: begin
				fire_0 = buttons[`LLAPI_BTN_7];
				fire_1 = buttons[`LLAPI_BTN_0];
				fire_2 = buttons[`LLAPI_BTN_1];
			end
			default: begin
				// Generic pads
				fire_0 = buttons[`LLAPI_BTN_2];
				fire_1 = buttons[`LLAPI_BTN_0];
				fire_2 = buttons[`LLAPI_BTN_1];
			end
		endcase
	end

	// D-pad, start and coin sit at fixed positions
	always_comb begin
		pad = '0;
		if (present) begin
			pad.up    = buttons[`LLAPI_BTN_UP];
			pad.down  = buttons[`LLAPI_BTN_DOWN];
			pad.left  = buttons[`LLAPI_BTN_LEFT];
			pad.right = buttons[`LLAPI_BTN_RIGHT];
			pad.b0    = fire_0;
			pad.b1    = fire_1;
			pad.b2    = fire_2;
			pad.start = buttons[`LLAPI_BTN_START];
			pad.coin  = buttons[`LLAPI_BTN_COIN];
		end
	end

	// Menu combo works even before the pad counts as present
	assign osd_combo = buttons[`LLAPI_BTN_DOWN] & buttons[`LLAPI_BTN_START] &
		buttons[`LLAPI_BTN_0];

endmodule

//--- src/download_config.sv
// Write strobe, index, address and data are valid in one cycle
// Only DIP bytes 0 and 1 are kept, other DIP addresses are dropped
`timescale 1ns/10ps
`include "arcade_input_config.svh"

module download_config import arcade_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_wr,
	input  byte_t       ioctl_index,
	input  dl_addr_t    ioctl_addr,
	input  byte_t       ioctl_data,
	output game_index_t game_index,
	output byte_t       dip_1,
	output byte_t       dip_2
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_index <= '0;
			dip_1      <= '0;
			dip_2      <= '0;
		end else if (ioctl_wr) begin
			// Game select uses the low nibble only
			if (ioctl_index == `DL_INDEX_GAME) begin
				game_index <= ioctl_data[3:0];
			end
			// DIP bank, first two bytes
			if (ioctl_index == `DL_INDEX_DIP) begin
				case (ioctl_addr)
					dl_addr_t'(0): dip_1 <= ioctl_data;
					dl_addr_t'(1): dip_2 <= ioctl_data;
					default: ;
				endcase
			end
		end
	end

endmodule

//--- src/player_control_merge.sv
// Keyboard and pad bits are ORed, outputs registered once
// Pause comes from the keyboard only
`timescale 1ns/10ps

module player_control_merge import arcade_input_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  kbd_keys_t    keys,
	input  pad_t         pad_1,
	input  pad_t         pad_2,
	input  logic         osd_1,
	input  logic         osd_2,
	output player_ctrl_t player_1,
	output player_ctrl_t player_2,
	output logic         pause,
	output logic         osd_button
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			player_1   <= '0;
			player_2   <= '0;
			pause      <= 1'b0;
			osd_button <= 1'b0;
		end else begin
			// Player 1 on cursor keys, ctrl, alt, space
			player_1.joy.up      <= keys.up    | pad_1.up;
			player_1.joy.down    <= keys.down  | pad_1.down;
			player_1.joy.left    <= keys.left  | pad_1.left;
			player_1.joy.right   <= keys.right | pad_1.right;
			player_1.buttons.b0  <= keys.ctrl  | pad_1.b0;
			player_1.buttons.b1  <= keys.alt   | pad_1.b1;
			player_1.buttons.b2  <= keys.space | pad_1.b2;
			player_1.start       <= keys.k1    | pad_1.start;
			player_1.coin        <= keys.k5    | pad_1.coin;

			// Player 2 on the RFDG cluster plus A, S, Q
			player_2.joy.up      <= keys.r     | pad_2.up;
			player_2.joy.down    <= keys.f     | pad_2.down;
			player_2.joy.left    <= keys.d     | pad_2.left;
			player_2.joy.right   <= keys.g     | pad_2.right;
			player_2.buttons.b0  <= keys.a     | pad_2.b0;
			player_2.buttons.b1  <= keys.s     | pad_2.b1;
			player_2.buttons.b2  <= keys.q     | pad_2.b2;
			player_2.start       <= keys.k2    | pad_2.start;
			player_2.coin        <= keys.k6    | pad_2.coin;

			pause      <= keys.p;
			// Either pad can raise the menu
			osd_button <= osd_1 | osd_2;
		end
	end

endmodule

//--- src/arcade_input_top.sv
// Player-input path, all on clk_sys with synchronous reset
// Pad changes reach the outputs after one edge
// Keyboard events need three edges, two in the decoder and one here
`timescale 1ns/10ps

module arcade_input_top import arcade_input_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  ps2_key_t       ps2_key,
	input  logic           pad_1_en,
	input  llapi_buttons_t pad_1_buttons,
	input  llapi_type_t    pad_1_type,
	input  logic           pad_2_en,
	input  llapi_buttons_t pad_2_buttons,
	input  llapi_type_t    pad_2_type,
	input  logic           ioctl_wr,
	input  byte_t          ioctl_index,
	input  dl_addr_t       ioctl_addr,
	input  byte_t          ioctl_data,
	output player_ctrl_t   player_1,
	output player_ctrl_t   player_2,
	output logic           pause,
	output logic           osd_button,
	output game_index_t    game_index,
	output byte_t          dip_1,
	output byte_t          dip_2
);

	kbd_keys_t keys;
	pad_t      pad_1;
	pad_t      pad_2;
	logic      osd_1;
	logic      osd_2;

	////////////////////////////////////////////////////////////////////////////
	// Input decoders
	////////////////////////////////////////////////////////////////////////////

	ps2_key_decoder u_ps2_key_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_key (ps2_key),
		.keys    (keys)
	);

	llapi_pad_mapper u_pad_1 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.link_en   (pad_1_en),
		.buttons   (pad_1_buttons),
		.pad_type  (pad_1_type),
		.pad       (pad_1),
		.osd_combo (osd_1)
	);

	llapi_pad_mapper u_pad_2 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.link_en   (pad_2_en),
		.buttons   (pad_2_buttons),
		.pad_type  (pad_2_type),
		.pad       (pad_2),
		.osd_combo (osd_2)
	);

	// Game select and DIP bytes from the download bus
	download_config u_download_config (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_data  (ioctl_data),
		.game_index  (game_index),
		.dip_1       (dip_1),
		.dip_2       (dip_2)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////////////////////

	player_control_merge u_player_control_merge (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.keys       (keys),
		.pad_1      (pad_1),
		.pad_2      (pad_2),
		.osd_1      (osd_1),
		.osd_2      (osd_2),
		.player_1   (player_1),
		.player_2   (player_2),
		.pause      (pause),
		.osd_button (osd_button)
	);

endmodule

//--- test/arcade_input_props.sv
// Output checks on arcade_input_top attached by bind
// Combo bits come from the raw pad words
// Presence plays no part in the menu check
`timescale 1ns/10ps
`include "arcade_input_config.svh"

module arcade_input_props import arcade_input_pkg::*; (
	input logic           clk_sys,
	input logic           reset,
	input logic           ioctl_wr,
	input llapi_buttons_t pad_1_buttons,
	input llapi_buttons_t pad_2_buttons,
	input player_ctrl_t   player_1,
	input player_ctrl_t   player_2,
	input logic           pause,
	input logic           osd_button,
	input game_index_t    game_index,
	input byte_t          dip_1,
	input byte_t          dip_2
);

	// Failure count added to the end-of-run total
	int   failures = 0;
	logic combo;

	// Down, start and bit 0 on either pad
	assign combo =
		(pad_1_buttons[`LLAPI_BTN_DOWN] & pad_1_buttons[`LLAPI_BTN_START] &
		pad_1_buttons[`LLAPI_BTN_0]) |
		(pad_2_buttons[`LLAPI_BTN_DOWN] & pad_2_buttons[`LLAPI_BTN_START] &
		pad_2_buttons[`LLAPI_BTN_0]);

	// Everything cleared by a reset edge
	reset_clears_outputs: assert property (@(posedge clk_sys)
		reset |=> (player_1 == '0 && player_2 == '0 && !pause && !osd_button &&
		game_index == '0 && dip_1 == '0 && dip_2 == '0))
	else begin
		failures++;
		$error("outputs not zero in the cycle after reset");
	end

	// DIP bytes move only on a write
	dip_hold_without_write: assert property (@(posedge clk_sys) disable iff (reset)
		!ioctl_wr |=> ($stable(dip_1) && $stable(dip_2)))
	else begin
		failures++;
		$error("DIP byte changed without a download write");
	end

	// Menu request needs the combo one cycle earlier
	osd_needs_combo: assert property (@(posedge clk_sys) disable iff (reset)
		osd_button |-> $past(combo))
	else begin
		failures++;
		$error("osd_button high without a pad menu combo");
	end

endmodule

bind arcade_input_top arcade_input_props u_props (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.ioctl_wr      (ioctl_wr),
	.pad_1_buttons (pad_1_buttons),
	.pad_2_buttons (pad_2_buttons),
	.player_1      (player_1),
	.player_2      (player_2),
	.pause         (pause),
	.osd_button    (osd_button),
	.game_index    (game_index),
	.dip_1         (dip_1),
	.dip_2         (dip_2)
);

//--- test/arcade_input_tb.sv
// Random stimulus from seed 11499, compared each cycle with a model
// Keyboard events show on the outputs three edges after they are driven
// Pad and download changes show after one edge
`timescale 1ns/10ps
`include "arcade_input_config.svh"

module arcade_input_tb import arcade_input_pkg::*; ();

	localparam int CLK_PERIOD      = 4;
	localparam int SEED            = 11499;
	localparam int RESET_CYCLES    = 4;
	localparam int PRESENCE_CYCLES = 60;
	localparam int KBD_CYCLES      = 300;
	localparam int PAD_CYCLES      = 300;
	localparam int MIXED_CYCLES    = 300;
	localparam int TOTAL_CYCLES    = 2 * (RESET_CYCLES + PRESENCE_CYCLES) +
		KBD_CYCLES + PAD_CYCLES + MIXED_CYCLES;
	localparam int WATCHDOG_NS     = (TOTAL_CYCLES + 200) * CLK_PERIOD;

	logic clk_sys;
	logic reset;
	ps2_key_t ps2_key;
	logic pad_1_en;
	llapi_buttons_t pad_1_buttons;
	llapi_type_t pad_1_type;
	logic pad_2_en;
	llapi_buttons_t pad_2_buttons;
	llapi_type_t pad_2_type;
	logic ioctl_wr;
	byte_t ioctl_index;
	dl_addr_t ioctl_addr;
	byte_t ioctl_data;
	player_ctrl_t player_1;
	player_ctrl_t player_2;
	logic pause;
	logic osd_button;
	game_index_t game_index;
	byte_t dip_1;
	byte_t dip_2;

	// Model state
	kbd_keys_t kb_now;
	kbd_keys_t kb_d1;
	kbd_keys_t kb_d2;
	logic last_toggle;
	logic seen_1;
	logic seen_2;
	player_ctrl_t exp_player_1;
	player_ctrl_t exp_player_2;
	logic exp_pause;
	logic exp_osd;
	game_index_t exp_game;
	byte_t exp_dip_1;
	byte_t exp_dip_2;
	int errors;

	// Stimulus knobs, pad_mode 0 unknown type, 1 any type, 2 link down
	int kbd_rate;
	int dl_rate;
	int pad_mode;

	// Same order as the kbd_keys_t fields, MSB first
	byte_t used_codes [19] = '{`PS2_CODE_UP, `PS2_CODE_DOWN, `PS2_CODE_LEFT,
		`PS2_CODE_RIGHT, `PS2_CODE_CTRL, `PS2_CODE_ALT, `PS2_CODE_SPACE,
		`PS2_CODE_1, `PS2_CODE_2, `PS2_CODE_5, `PS2_CODE_6, `PS2_CODE_A,
		`PS2_CODE_S, `PS2_CODE_Q, `PS2_CODE_R, `PS2_CODE_F, `PS2_CODE_D,
		`PS2_CODE_G, `PS2_CODE_P};

	arcade_input_top u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Bit position in kbd_keys_t, -1 for a code not in the table
	function automatic int key_bit(byte_t code);
		for (int i = 0; i < 19; i++) begin
			if (used_codes[i] == code) return 18 - i;
		end
		return -1;
	endfunction

	function automatic byte_t unused_code();
		byte_t code;
		code = $urandom;
		while (key_bit(code) >= 0) code = $urandom;
		return code;
	endfunction

	// Presence rule, then the layout table by type
	function automatic pad_t map_pad(logic en, llapi_buttons_t b, llapi_type_t t,
		logic seen);
		pad_t p;
		p = '0;
		if (en && ((t != 8'd0 && t != 8'd255) || seen)) begin
			p.up    = b[27];
			p.down  = b[26];
			p.left  = b[25];
			p.right = b[24];
			p.start = b[5];
			p.coin  = b[4];
			case (t)
				`LLAPI_TYPE_SIX_A, `LLAPI_TYPE_SIX_B, `LLAPI_TYPE_SIX_C,
				`LLAPI_TYPE_SIX_D, `LLAPI_TYPE_SIX_E: begin
					p.b0 = b[0];
					p.b1 = b[1];
					p.b2 = b[7];
				end
				`LLAPI_TYPE_NEC_AVENUE: begin
					p.b0 = b[7];
					p.b1 = b[0];
					p.b2 = b[1];
				end
				default: begin
					p.b0 = b[2];
					p.b1 = b[0];
					p.b2 = b[1];
				end
			endcase
		end
		return p;
	endfunction

	// OR merge, keys given in pad_t order
	function automatic player_ctrl_t player_from(pad_t kb, pad_t p);
		pad_t both;
		player_ctrl_t w;
		both = kb | p;
		w.joy.up      = both.up;
		w.joy.down    = both.down;
		w.joy.right   = both.right;
		w.joy.left    = both.left;
		w.buttons.b2  = both.b2;
		w.buttons.b1  = both.b1;
		w.buttons.b0  = both.b0;
		w.start       = both.start;
		w.coin        = both.coin;
		return w;
	endfunction

	function automatic logic menu_combo(llapi_buttons_t b);
		return b[26] & b[5] & b[0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic llapi_buttons_t random_buttons();
		// Mostly idle while waiting for the first button
		if (pad_mode == 0 && ($urandom % 10) != 0) return '0;
		return $urandom;
	endfunction

	function automatic llapi_type_t random_type();
		llapi_type_t six [5];
		six = '{`LLAPI_TYPE_SIX_A, `LLAPI_TYPE_SIX_B, `LLAPI_TYPE_SIX_C,
			`LLAPI_TYPE_SIX_D, `LLAPI_TYPE_SIX_E};
		if (pad_mode == 0) return (($urandom % 2) != 0) ? 8'd0 : 8'd255;
		case ($urandom % 4)
			0: return six[$urandom % 5];
			1: return `LLAPI_TYPE_NEC_AVENUE;
			2: return $urandom;
			default: return (($urandom % 2) != 0) ? 8'd0 : 8'd255;
		endcase
	endfunction

	function automatic logic random_en();
		if (pad_mode == 2) return 1'b0;
		if (pad_mode == 0) return $urandom % 2;
		return ($urandom % 8) != 0;
	endfunction

	// Drives one cycle of inputs and predicts the outputs after the next edge
	task automatic drive_inputs();
		ps2_key_t key;
		kbd_keys_t kb;
		pad_t kb1;
		pad_t kb2;
		int bit_pos;
		key = ps2_key;
		if (($urandom % 100) < kbd_rate) begin
			key[7:0] = (($urandom % 4) == 0) ? unused_code() : used_codes[$urandom % 19];
			key[8]   = $urandom;
			key[9]   = $urandom;
			// Now and then a repeated toggle, which is no event
			key[10]  = (($urandom % 6) == 0) ? last_toggle : !last_toggle;
		end
		ps2_key = key;
		if (key[10] != last_toggle) begin
			bit_pos = key_bit(key[7:0]);
			if (bit_pos >= 0) kb_now[bit_pos] = key[9];
		end
		last_toggle = key[10];

		pad_1_en      = random_en();
		pad_1_buttons = random_buttons();
		pad_1_type    = random_type();
		pad_2_en      = random_en();
		pad_2_buttons = random_buttons();
		pad_2_type    = random_type();

		ioctl_wr = ($urandom % 100) < dl_rate;
		case ($urandom % 3)
			0: ioctl_index = `DL_INDEX_GAME;
			1: ioctl_index = `DL_INDEX_DIP;
			default: ioctl_index = $urandom;
		endcase
		ioctl_addr = (($urandom % 8) == 0) ? dl_addr_t'($urandom) : dl_addr_t'($urandom % 3);
		ioctl_data = $urandom;

		// Key state applied two cycles back reaches the outputs now
		kb  = kb_d2;
		kb1 = {kb.up, kb.down, kb.left, kb.right, kb.ctrl, kb.alt, kb.space, kb.k1, kb.k5};
		kb2 = {kb.r, kb.f, kb.d, kb.g, kb.a, kb.s, kb.q, kb.k2, kb.k6};
		kb_d2 = kb_d1;
		kb_d1 = kb_now;

		exp_player_1 = player_from(kb1, map_pad(pad_1_en, pad_1_buttons, pad_1_type, seen_1));
		exp_player_2 = player_from(kb2, map_pad(pad_2_en, pad_2_buttons, pad_2_type, seen_2));
		exp_pause    = kb.p;
		exp_osd      = menu_combo(pad_1_buttons) | menu_combo(pad_2_buttons);
		seen_1 = seen_1 | (|pad_1_buttons);
		seen_2 = seen_2 | (|pad_2_buttons);

		if (ioctl_wr) begin
			if (ioctl_index == 8'd1) exp_game = ioctl_data[3:0];
			if (ioctl_index == 8'd254 && ioctl_addr == 0) exp_dip_1 = ioctl_data;
			if (ioctl_index == 8'd254 && ioctl_addr == 1) exp_dip_2 = ioctl_data;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks and sequencing
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_outputs();
		check_value("player_1", exp_player_1, player_1);
		check_value("player_2", exp_player_2, player_2);
		check_value("pause", exp_pause, pause);
		check_value("osd_button", exp_osd, osd_button);
		check_value("game_index", exp_game, game_index);
		check_value("dip_1", exp_dip_1, dip_1);
		check_value("dip_2", exp_dip_2, dip_2);
	endtask

	// Three reset edges, inputs idle, then all outputs zero
	task automatic apply_reset();
		reset = 1'b1;
		ps2_key = '0;
		{pad_1_en, pad_1_buttons, pad_1_type} = '0;
		{pad_2_en, pad_2_buttons, pad_2_type} = '0;
		{ioctl_wr, ioctl_index, ioctl_addr, ioctl_data} = '0;
		{kb_now, kb_d1, kb_d2, last_toggle, seen_1, seen_2} = '0;
		{exp_player_1, exp_player_2, exp_pause, exp_osd} = '0;
		{exp_game, exp_dip_1, exp_dip_2} = '0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		check_outputs();
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			drive_inputs();
			@(negedge clk_sys);
			check_outputs();
		end
	endtask

	initial begin
		void'($urandom(SEED));
		errors = 0;
		apply_reset();

		// Unknown pad types until the first button, keyboard and downloads idle
		{kbd_rate, dl_rate, pad_mode} = {32'd0, 32'd0, 32'd0};
		run_cycles(PRESENCE_CYCLES);
		// Keyboard with both links down
		{kbd_rate, dl_rate, pad_mode} = {32'd60, 32'd0, 32'd2};
		run_cycles(KBD_CYCLES);
		// Pad layouts over the type groups
		{kbd_rate, dl_rate, pad_mode} = {32'd20, 32'd0, 32'd1};
		run_cycles(PAD_CYCLES);
		// Downloads mixed with everything else
		{kbd_rate, dl_rate, pad_mode} = {32'd30, 32'd50, 32'd1};
		run_cycles(MIXED_CYCLES);

		// Second reset clears the seen flags
		apply_reset();
		{kbd_rate, dl_rate, pad_mode} = {32'd10, 32'd20, 32'd0};
		run_cycles(PRESENCE_CYCLES);

		errors = errors + u_dut.u_props.failures;
		$display("Run complete, %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout, the test sequence did not complete in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- files.f
+incdir+src
src/arcade_input_pkg.sv
src/ps2_key_decoder.sv
src/llapi_pad_mapper.sv
src/download_config.sv
src/player_control_merge.sv
src/arcade_input_top.sv
test/arcade_input_props.sv
test/arcade_input_tb.sv
